// File: testbench/sample_patterns.txt
# base0 base1 (hex word addresses), tick gap in clock cycles, expected first sample (hex)
# Lane k of word A is A[13:0] followed by k, a sample is the saturated sum of both voices
00000100 00000200 20 0c00
00001000 00000040 2 4100
00001f00 00001e00 6 7fff
00002000 00002100 4 8000
1abc0000 00003ff0 3 ffc0
00001fe0 00000100 2 7fff

// File: flist.f
+incdir+common
common/mem_pkg.sv
common/audio_pkg.sv
common/mem_read_if.sv
rtl/fetch/sample_fetcher.sv
rtl/mem_arbiter.sv
rtl/sample_mixer.sv
rtl/sample_player.sv
testbench/tb_mem_model.sv
testbench/tb_sample_player.sv

// File: Bender.yml
package:
  name: sample_player

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - common/audio_pkg.sv
      - common/mem_read_if.sv
      - rtl/fetch/sample_fetcher.sv
      - rtl/mem_arbiter.sv
      - rtl/sample_mixer.sv
      - rtl/sample_player.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_sample_player.sv

// File: testbench/tb_sample_player.sv
`timescale 1ns/10ps
`default_nettype none

`include "sampler_params.svh"

// Plays each buffer pair from the pattern file and checks every mixed sample
module tb_sample_player
	import mem_pkg::*;
	import audio_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 200;
	localparam int CHUNKS = 1 << `SAMPLER_CHUNK_ADDR_W;
	localparam int SAMPLES_PER_BUFFER = CHUNKS * `SAMPLER_LANES;

	logic      clock;
	logic      reset_l;
	mem_word_t mem_data;
	logic      mem_ack;
	logic      mem_wait;
	mem_addr_t mem_addr;
	logic      mem_read_en;
	mem_addr_t base0, base1;
	logic      base0_valid, base0_ack, base1_valid, base1_ack;
	logic      sample_tick;
	sample_t   sample;
	logic      sample_valid, underrun;

	// Address that each voice must read next in the current case
	mem_addr_t next_read0;
	mem_addr_t next_read1;

	sample_player sample_player_inst (
		.clock (clock), .reset_l (reset_l),
		.mem_data (mem_data), .mem_ack (mem_ack), .mem_wait (mem_wait),
		.mem_addr (mem_addr), .mem_read_en (mem_read_en),
		.base0 (base0), .base0_valid (base0_valid), .base0_ack (base0_ack),
		.base1 (base1), .base1_valid (base1_valid), .base1_ack (base1_ack),
		.sample_tick (sample_tick), .sample (sample),
		.sample_valid (sample_valid), .underrun (underrun)
	);

	tb_mem_model mem_model_inst (
		.clock (clock), .reset_l (reset_l),
		.mem_addr (mem_addr), .mem_read_en (mem_read_en),
		.mem_data (mem_data), .mem_ack (mem_ack), .mem_wait (mem_wait)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	// Every issued read must be the next chunk of one of the two buffers
	always @(posedge clock) begin
		if (reset_l && mem_read_en && !mem_wait) begin
			if (mem_addr == next_read0) begin
				next_read0 = next_read0 + 1'b1;
			end else begin
				check_value("mem_addr", mem_addr, next_read1);
				next_read1 = next_read1 + 1'b1;
			end
		end
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("MISMATCH time=%0t signal=%s got=%0h expected=%0h",
				$time, name, got, expected);
			stop_run("A checked value was wrong");
		end
	endtask

	// Lane k of word A is A[13:0] followed by k
	function automatic sample_t lane_value(input mem_addr_t addr, input int lane);
		return {addr[13:0], 2'(lane)};
	endfunction

	function automatic sample_t saturate_sum(input sample_t a, input sample_t b);
		int total;
		total = int'(a) + int'(b);
		if (total > 32767)
			return 16'sh7fff;
		if (total < -32768)
			return 16'sh8000;
		return sample_t'(total);
	endfunction

	// Sample n of a buffer comes from chunk n/4 at base plus chunk, lane n%4
	function automatic sample_t expected_sample(input mem_addr_t b0, input mem_addr_t b1,
			input int index);
		int chunk;
		int lane;
		chunk = index / `SAMPLER_LANES;
		lane = index % `SAMPLER_LANES;
		return saturate_sum(lane_value(b0 + mem_addr_t'(chunk), lane),
			lane_value(b1 + mem_addr_t'(chunk), lane));
	endfunction

	// Called 1 ns after an edge, returns 1 ns after the edge where both bases were taken
	task automatic give_bases(input mem_addr_t addr0, input mem_addr_t addr1);
		int cycles;
		logic got0;
		logic got1;
		cycles = 0;
		got0 = 1'b0;
		got1 = 1'b0;
		base0 = addr0;
		base1 = addr1;
		base0_valid = 1'b1;
		base1_valid = 1'b1;
		while (!(got0 && got1)) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				stop_run("Timeout while waiting for base_ack");
			@(posedge clock);
			got0 = got0 | base0_ack;
			got1 = got1 | base1_ack;
			#1;
			if (got0)
				base0_valid = 1'b0;
			if (got1)
				base1_valid = 1'b0;
		end
	endtask

	// Both buffers are active, so new bases must be ignored
	task automatic offer_base_while_busy(input mem_addr_t addr0, input mem_addr_t addr1);
		base0 = addr0;
		base1 = addr1;
		base0_valid = 1'b1;
		base1_valid = 1'b1;
		repeat (3) begin
			@(posedge clock);
			check_value("base0_ack", base0_ack, 0);
			check_value("base1_ack", base1_ack, 0);
			#1;
		end
		base0_valid = 1'b0;
		base1_valid = 1'b0;
	endtask

	// One tick pulse, then the registered result exactly one cycle later
	task automatic play_tick(output sample_t got, output logic got_under);
		sample_tick = 1'b1;
		@(posedge clock);
		// Ticks are at least two cycles apart so the last result has gone
		check_value("sample_valid", sample_valid, 0);
		#1 sample_tick = 1'b0;
		@(posedge clock);
		check_value("sample_valid", sample_valid, 1);
		got = sample;
		got_under = underrun;
		#1;
	endtask

	task automatic run_case(input mem_addr_t b0, input mem_addr_t b1, input int gap,
			input sample_t first);
		int index;
		int underruns;
		int stalls;
		sample_t got;
		logic got_under;
		next_read0 = b0;
		next_read1 = b1;
		index = 0;
		underruns = 0;
		stalls = 0;
		give_bases(b0, b1);
		offer_base_while_busy(~b0, ~b1);
		while (index < SAMPLES_PER_BUFFER) begin
			play_tick(got, got_under);
			if (got_under) begin
				// Silence is played and the same lane is tried again
				check_value("sample", got, 0);
				underruns++;
				stalls++;
				if (stalls > TIMEOUT_CYCLES)
					stop_run("Timeout because underrun never cleared");
			end else begin
				if (index == 0)
					check_value("first sample", got, first);
				check_value("sample", got, expected_sample(b0, b1, index));
				stalls = 0;
				index++;
			end
			repeat (gap - 2) begin
				@(posedge clock);
				#1;
			end
		end
		// A chunk cannot be refetched within two cycles of its release
		if (gap == 2 && underruns == 0)
			stop_run("Ticks every second cycle produced no underrun");
		repeat (20) begin
			@(posedge clock);
			check_value("mem_read_en", mem_read_en, 0);
			#1;
		end
		// Each voice read exactly its own 64 chunks
		check_value("next_read0", next_read0, b0 + mem_addr_t'(CHUNKS));
		check_value("next_read1", next_read1, b1 + mem_addr_t'(CHUNKS));
		$display("Case base0=%h base1=%h gap=%0d underruns=%0d done", b0, b1, gap, underruns);
	endtask

	initial begin : main_sequence
		int fd;
		int fields;
		int cases;
		int gap;
		string line;
		mem_addr_t b0;
		mem_addr_t b1;
		logic [15:0] first;
		reset_l = 1'b0;
		sample_tick = 1'b0;
		base0 = '0;
		base1 = '0;
		base0_valid = 1'b0;
		base1_valid = 1'b0;
		next_read0 = '0;
		next_read1 = '0;
		cases = 0;
		repeat (10) @(posedge clock);
		#1 reset_l = 1'b1;
		fd = $fopen("testbench/sample_patterns.txt", "r");
		if (fd == 0)
			stop_run("Cannot open testbench/sample_patterns.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%h %h %d %h", b0, b1, gap, first);
			if (fields != 4 || gap < 2)
				stop_run("Malformed line in the pattern file");
			run_case(b0, b1, gap, sample_t'(first));
			cases++;
		end
		$fclose(fd);
		if (cases == 0) begin
			stop_run("The pattern file holds no test case");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule : tb_sample_player

`default_nettype wire

// File: testbench/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "sampler_params.svh"

// DDR3 read port model with a random stall before each read and a random response latency
// Lane k of the word at address A holds the low 14 bits of A followed by the two bits of k
module tb_mem_model
	import mem_pkg::*;
(
	input  wire            clock,
	input  wire            reset_l,
	input  wire mem_addr_t mem_addr,
	input  wire            mem_read_en,
	output mem_word_t      mem_data,
	output logic           mem_ack,
	output logic           mem_wait
);

	logic [31:0] rng;
	// Set from the issuing edge until the ack cycle has passed
	logic        busy;
	logic [1:0]  ack_delay;
	// Stall cycles still owed by the next request
	logic [1:0]  wait_left;
	mem_addr_t   read_addr;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic mem_word_t word_at(input mem_addr_t addr);
		mem_word_t word;
		for (int k = 0; k < `SAMPLER_LANES; k++)
			word[k*16 +: 16] = {addr[13:0], 2'(k)};
		return word;
	endfunction

	initial begin
		rng = 32'h1298;
		busy = 1'b0;
		ack_delay = '0;
		wait_left = '0;
		read_addr = '0;
		mem_data = '0;
		mem_ack = 1'b0;
		mem_wait = 1'b0;
	end

	// Bus values are taken at the edge and the new response goes out 1 ns later
	always @(posedge clock) begin
		if (!reset_l) begin
			busy = 1'b0;
			wait_left = '0;
		end else begin
			if (mem_ack)
				busy = 1'b0;
			else if (busy && ack_delay != 0)
				ack_delay = ack_delay - 1'b1;
			// A stalled request uses up one of its wait cycles
			if (mem_read_en && mem_wait)
				wait_left = wait_left - 1'b1;
			if (!busy && mem_read_en && !mem_wait) begin
				busy = 1'b1;
				read_addr = mem_addr;
				rng = lcg_next(rng);
				ack_delay = rng[17:16];
				wait_left = rng[21:20];
			end
		end
		#1;
		mem_ack = busy && (ack_delay == 0);
		mem_data = mem_ack ? word_at(read_addr) : '0;
		mem_wait = (wait_left != 0);
	end

endmodule : tb_mem_model

`default_nettype wire

// File: rtl/sample_player.sv
`timescale 1ns/10ps
`default_nettype none

// Two voice sample player built from two fetchers, one arbiter and a mixer
module sample_player
	import mem_pkg::*;
	import audio_pkg::*;
(
	input  wire            clock,
	input  wire            reset_l,

	input  wire mem_word_t mem_data,
	input  wire            mem_ack,
	input  wire            mem_wait,
	output mem_addr_t      mem_addr,
	output logic           mem_read_en,

	input  wire mem_addr_t base0,
	input  wire            base0_valid,
	output logic           base0_ack,
	input  wire mem_addr_t base1,
	input  wire            base1_valid,
	output logic           base1_ack,

	input  wire            sample_tick,
	output sample_t        sample,
	output logic           sample_valid,
	output logic           underrun
);

	// Private read port of each voice in front of the arbiter
	mem_read_if voice0_mem ();
	mem_read_if voice1_mem ();

	chunk_u chunk0, chunk1;
	logic chunk0_valid, chunk1_valid;
	// The mixer releases both voices at once
	logic chunk_ack;

	sample_fetcher fetch0_inst (
		.clock       (clock),
		.reset_l     (reset_l),
		.mem         (voice0_mem.requester),
		.chunk       (chunk0),
		.chunk_valid (chunk0_valid),
		.chunk_addr  (),
		.chunk_ack   (chunk_ack),
		.base        (base0),
		.base_valid  (base0_valid),
		.base_ack    (base0_ack)
	);

	sample_fetcher fetch1_inst (
		.clock       (clock),
		.reset_l     (reset_l),
		.mem         (voice1_mem.requester),
		.chunk       (chunk1),
		.chunk_valid (chunk1_valid),
		.chunk_addr  (),
		.chunk_ack   (chunk_ack),
		.base        (base1),
		.base_valid  (base1_valid),
		.base_ack    (base1_ack)
	);

	mem_arbiter arbiter_inst (
		.clock       (clock),
		.reset_l     (reset_l),
		.voice0      (voice0_mem.memory),
		.voice1      (voice1_mem.memory),
		.mem_addr    (mem_addr),
		.mem_read_en (mem_read_en),
		.mem_data    (mem_data),
		.mem_ack     (mem_ack),
		.mem_wait    (mem_wait)
	);

	sample_mixer mixer_inst (
		.clock        (clock),
		.reset_l      (reset_l),
		.chunk0       (chunk0),
		.chunk1       (chunk1),
		.chunk0_valid (chunk0_valid),
		.chunk1_valid (chunk1_valid),
		.sample_tick  (sample_tick),
		.chunk_ack    (chunk_ack),
		.sample       (sample),
		.sample_valid (sample_valid),
		.underrun     (underrun)
	);

endmodule : sample_player

`default_nettype wire

// File: rtl/sample_mixer.sv
`timescale 1ns/10ps
`default_nettype none

`include "sampler_params.svh"

// Adds one lane of each voice per sample tick with 16-bit saturation
module sample_mixer
	import audio_pkg::*;
(
	input  wire         clock,
	input  wire         reset_l,

	input  wire chunk_u chunk0,
	input  wire chunk_u chunk1,
	input  wire         chunk0_valid,
	input  wire         chunk1_valid,
	input  wire         sample_tick,
	output logic        chunk_ack,

	output sample_t     sample,
	output logic        sample_valid,
	output logic        underrun
);

	typedef logic [$clog2(`SAMPLER_LANES)-1:0] lane_idx_t;

	// Lane of both chunks that the next tick plays
	lane_idx_t lane_sel;
	logic both_valid;
	// One extra bit holds the carry of the signed add
	logic signed [16:0] sum;
	sample_t sum_sat;

	always_comb begin
		both_valid = chunk0_valid & chunk1_valid;

		sum = 17'(chunk0.lanes[lane_sel]) + 17'(chunk1.lanes[lane_sel]);
		// Overflow shows as the two top bits disagreeing
		if (sum[16] != sum[15])
			sum_sat = sum[16] ? 16'sh8000 : 16'sh7fff;
		else
			sum_sat = sum[15:0];

		// Both chunks are released together after their last lane is played
		chunk_ack = sample_tick & both_valid & (lane_sel == lane_idx_t'(`SAMPLER_LANES - 1));
	end

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			lane_sel <= '0;
			sample_valid <= 1'b0;
			underrun <= 1'b0;
		end else begin
			sample_valid <= sample_tick;
			underrun <= sample_tick & ~both_valid;
			// on underrun the lane stays put so nothing is skipped
			if (sample_tick && both_valid)
				lane_sel <= lane_sel + lane_idx_t'(1);
		end
	end

	// Output is silence whenever either voice has no data
	always_ff @(posedge clock) begin
		if (sample_tick)
			sample <= both_valid ? sum_sat : '0;
	end

	// Both fetchers must empty their chunk slot on the cycle after the release
	assert property (@(posedge clock) disable iff (!reset_l)
		chunk_ack |=> (!chunk0_valid && !chunk1_valid));

endmodule : sample_mixer

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

// Shares the one DDR3 read port between the two voice fetchers
// Only one read is in flight at a time so the owner is known when ack returns
module mem_arbiter
	import mem_pkg::*;
(
	input  wire            clock,
	input  wire            reset_l,

	mem_read_if.memory     voice0,
	mem_read_if.memory     voice1,

	output mem_addr_t      mem_addr,
	output logic           mem_read_en,
	input  wire mem_word_t mem_data,
	input  wire            mem_ack,
	input  wire            mem_wait
);

	// Set from issue until ack
	logic busy;
	// Voice that owns the outstanding read, and so the voice served last
	logic owner;
	// Voice picked in this cycle, 1 selects voice1
	logic sel;
	logic issue;

	always_comb begin
		// With both voices asking, the one not served last goes first
		if (voice0.read_en && voice1.read_en)
			sel = ~owner;
		else
			sel = voice1.read_en;

		mem_read_en = ~busy & (voice0.read_en | voice1.read_en);
		mem_addr = sel ? voice1.addr : voice0.addr;
		issue = mem_read_en & ~mem_wait;

		// A voice that is not granted sees a stall
		voice0.wait_req = busy | sel | mem_wait;
		voice1.wait_req = busy | ~sel | mem_wait;

		voice0.ack = mem_ack & busy & ~owner;
		voice1.ack = mem_ack & busy & owner;
		voice0.data = mem_data;
		voice1.data = mem_data;
	end

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			busy <= 1'b0;
			owner <= 1'b0;
		end else begin
			if (issue) begin
				busy <= 1'b1;
				owner <= sel;
			end else if (mem_ack) begin
				busy <= 1'b0;
			end
		end
	end

	// The memory side must answer only reads that were issued, and each only once
	assert property (@(posedge clock) disable iff (!reset_l)
		mem_ack |-> busy);

endmodule : mem_arbiter

`default_nettype wire

// File: rtl/fetch/sample_fetcher.sv
`timescale 1ns/10ps
`default_nettype none

`include "sampler_params.svh"

// Fetches 64 chunks for one voice starting at a software supplied base
// A new base is taken only once the previous buffer has been fully read
module sample_fetcher
	import mem_pkg::*;
	import audio_pkg::*;
(
	input  wire                              clock,
	input  wire                              reset_l,

	mem_read_if.requester                    mem,

	output chunk_u                           chunk,
	output logic                             chunk_valid,
	output logic [`SAMPLER_CHUNK_ADDR_W-1:0] chunk_addr,
	input  wire                              chunk_ack,

	input  wire mem_addr_t                   base,
	input  wire                              base_valid,
	output logic                             base_ack
);

	typedef enum logic {
		IDLE,
		READ_WAIT
	} ram_state_t;

	// Base of the buffer that is being read
	mem_addr_t addr, next_addr;
	logic addr_valid, next_addr_valid;

	logic [`SAMPLER_CHUNK_ADDR_W-1:0] next_chunk_addr;
	// High while the counter points at the final chunk of the buffer
	logic last_chunk;
	logic next_chunk_valid;

	ram_state_t ram_state, next_ram_state;

	always_comb begin
		last_chunk = &chunk_addr;

		// A base is only accepted when no buffer is active
		base_ack = ~addr_valid & base_valid;
		next_addr = base_ack ? base : addr;
		if (base_ack)
			next_addr_valid = 1'b1;
		else if (mem.ack && last_chunk)
			next_addr_valid = 1'b0;
		else
			next_addr_valid = addr_valid;

		mem.addr = addr + mem_addr_t'(chunk_addr);

		unique case (ram_state)
			IDLE: begin
				// Only ask for data once the held chunk has been consumed
				mem.read_en = ~chunk_valid & addr_valid;
				next_ram_state = (mem.read_en && !mem.wait_req) ? READ_WAIT : IDLE;
				next_chunk_valid = chunk_valid & ~chunk_ack;
				next_chunk_addr = chunk_addr;
			end
			READ_WAIT: begin
				mem.read_en = 1'b0;
				next_ram_state = mem.ack ? IDLE : READ_WAIT;
				next_chunk_valid = mem.ack;
				// Counter wraps to zero after the 64th word, ready for the next base
				next_chunk_addr = mem.ack ? chunk_addr + 1'b1 : chunk_addr;
			end
		endcase
	end

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			addr <= '0;
			addr_valid <= 1'b0;
			chunk_addr <= '0;
			chunk_valid <= 1'b0;
			ram_state <= IDLE;
		end else begin
			addr <= next_addr;
			addr_valid <= next_addr_valid;
			chunk_addr <= next_chunk_addr;
			chunk_valid <= next_chunk_valid;
			ram_state <= next_ram_state;
		end
	end

	// Returned word is captured only on ack
	always_ff @(posedge clock) begin
		if (ram_state == READ_WAIT && mem.ack)
			chunk.raw <= mem.data;
	end

	// A new buffer starts at its first chunk with no read in flight
	assert property (@(posedge clock) disable iff (!reset_l)
		base_ack |-> (ram_state == IDLE && chunk_addr == '0));

	// While the single chunk slot is full no read is in flight for this voice
	assert property (@(posedge clock) disable iff (!reset_l)
		chunk_valid |-> (ram_state == IDLE && !mem.ack));

endmodule : sample_fetcher

`default_nettype wire

// File: common/mem_read_if.sv
`timescale 1ns/10ps
`default_nettype none

// One memory read port between a requester and the memory side
interface mem_read_if
	import mem_pkg::*;
();

	mem_addr_t addr;
	logic      read_en;
	// Stall from the memory side while read_en is held
	// wait is a reserved word so the signal is called wait_req
	logic      wait_req;
	// Pulses once per issued read together with valid data
	logic      ack;
	mem_word_t data;

	modport requester (
		output addr, read_en,
		input  wait_req, ack, data
	);

	modport memory (
		input  addr, read_en,
		output wait_req, ack, data
	);

endinterface : mem_read_if

`default_nettype wire

// File: common/audio_pkg.sv
`default_nettype none

`include "sampler_params.svh"

// Types that describe audio samples and how they sit in a memory word
package audio_pkg;

	import mem_pkg::*;

	// One signed PCM sample
	typedef logic signed [15:0] sample_t;

	// All lanes of one chunk with lane 0 in the low bits
	typedef sample_t [`SAMPLER_LANES-1:0] lanes_t;

	// A chunk is stored by the fetcher as a raw memory word
	// The mixer reads the same bits back as separate sample lanes
	typedef union packed {
		mem_word_t raw;
		lanes_t    lanes;
	} chunk_u;

endpackage : audio_pkg

`default_nettype wire

// File: common/mem_pkg.sv
`default_nettype none

`include "sampler_params.svh"

// Types that describe the DDR3 read side
package mem_pkg;

	// Address of one 64-bit word in DDR3
	typedef logic [`SAMPLER_ADDR_W-1:0] mem_addr_t;

	// One word as returned by the memory read port
	typedef logic [63:0] mem_word_t;

endpackage : mem_pkg

`default_nettype wire

// File: common/sampler_params.svh
`ifndef SAMPLER_PARAMS_SVH
`define SAMPLER_PARAMS_SVH

// Fixed sizes shared by the memory side and the audio side of the player

// Width of a DDR3 word address where one word is 64 bits
`define SAMPLER_ADDR_W 29

// Width of the chunk counter inside a fetcher
// Six bits give 64 chunks, which is 512 bytes per buffer
`define SAMPLER_CHUNK_ADDR_W 6

// Number of 16-bit samples packed into one 64-bit chunk
// Lane 0 sits in the low bits of the word
`define SAMPLER_LANES 4

`endif
